//--- Makefile
# Verilator build and run of the instruction queue testbench
# The run passes only when the log holds the pass line

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps -j 0 \
		--top-module iq_tb -f list.f --Mdir obj_dir -o iq_sim
	./obj_dir/iq_sim | tee sim.log
	grep -qx "Finished with no errors" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean

//--- list.f
+incdir+src
src/iq_pkg.sv
src/iq_tail.sv
src/iq_stomp.sv
src/iq_store.sv
src/iq_top.sv
sim/iq_tb.sv

//--- sim/iq_tb.sv
/* Self-checking testbench for iq_top. A cycle model predicts every output, and
   concurrent assertions compare it with the DUT at each rising edge */
`timescale 1ns/1ps
`include "iq_macros.svh"

module iq_tb;

    localparam int DEPTH = `IQ_DEPTH;
    localparam int PTR_W = `IQ_PTR_W;

    logic                  clk = 1'b0;
    logic                  rst;
    iq_pkg::fetch_slot_t   fetch0;
    iq_pkg::fetch_slot_t   fetch1;
    logic                  retire;
    logic                  branchmiss;
    logic [PTR_W-1:0]      miss_idx;
    logic                  take0;
    logic                  take1;
    logic [PTR_W-1:0]      tail0;
    logic [PTR_W-1:0]      tail1;
    logic [PTR_W-1:0]      head;
    iq_pkg::iq_entry_t     head_entry;

    // Reference model of the queue contents and pointers
    logic [DEPTH-1:0]                  m_v;
    iq_pkg::instruction_t [DEPTH-1:0]  m_ins;
    logic [PTR_W-1:0]                  m_tail;
    logic [PTR_W-1:0]                  m_head;
    logic                              exp_take0;
    logic                              exp_take1;

    int errors = 0;
    int test_num = 0;
    int tests_failed = 0;
    int errs_at_start = 0;

    iq_top dut_i (
        .clk, .rst, .fetch0, .fetch1, .retire, .branchmiss, .miss_idx,
        .take0, .take1, .tail0, .tail1, .head, .head_entry
    );

    always #4 clk = ~clk;

    // ======================================================================
    // Reference model
    // ======================================================================

    // Negative displacement on the branch opcode means a loop back edge
    function automatic logic points_backward(iq_pkg::instruction_t ins);
        return (ins.br.opcode == `OP_BRANCH) && ($signed(ins.br.disp) < 0);
    endfunction

    // Accept strobes follow the enqueue rules for the current cycle
    always_comb begin
        exp_take0 = 1'b0;
        exp_take1 = 1'b0;
        if (!branchmiss && !m_v[m_tail]) begin
            if (fetch0.v) begin
                exp_take0 = 1'b1;
                exp_take1 = fetch1.v && !m_v[m_tail + 1'b1] && !points_backward(fetch0.instr);
            end else begin
                exp_take1 = fetch1.v;
            end
        end
    end

    always @(posedge clk or posedge rst) begin : model_step
        logic [DEPTH-1:0] nv;
        logic [PTR_W-1:0] idx;
        logic [PTR_W-1:0] roll;
        logic             hit;
        if (rst) begin
            m_v    <= '0;
            m_ins  <= '0;
            m_tail <= '0;
            m_head <= '0;
        end else begin
            nv = m_v;
            if (retire && m_v[m_head]) begin
                nv[m_head] = 1'b0;
                m_head <= m_head + 1'b1;
            end
            if (branchmiss) begin
                // Walk from the entry after the branch up to tail0
                // The first younger valid entry becomes the new tail
                hit  = 1'b0;
                roll = m_tail;
                for (int k = 1; k < DEPTH; k++) begin
                    idx = miss_idx + PTR_W'(k);
                    if (idx == m_tail) break;
                    if (m_v[idx]) begin
                        nv[idx] = 1'b0;
                        if (!hit) roll = idx;
                        hit = 1'b1;
                    end
                end
                m_tail <= roll;
            end else begin
                // A lone slot 1 lands at tail0 just like slot 0
                if (exp_take0 || exp_take1) begin
                    nv[m_tail] = 1'b1;
                    m_ins[m_tail] <= exp_take0 ? fetch0.instr : fetch1.instr;
                end
                if (exp_take0 && exp_take1) begin
                    nv[m_tail + 1'b1] = 1'b1;
                    m_ins[m_tail + 1'b1] <= fetch1.instr;
                end
                m_tail <= m_tail + PTR_W'(exp_take0) + PTR_W'(exp_take1);
            end
            m_v <= nv;
        end
    end

    // ======================================================================
    // Checks against the model
    // ======================================================================

    task automatic report_mismatch(input string name, input logic [63:0] got,
                                   input logic [63:0] exp);
        errors++;
        $display("CHECK FAILED at %0t: %s is %0h, expected %0h", $time, name, got, exp);
    endtask

    a_take0: assert property (@(posedge clk) disable iff (rst) take0 == exp_take0)
        else report_mismatch("take0", 64'($sampled(take0)), 64'($sampled(exp_take0)));
    a_take1: assert property (@(posedge clk) disable iff (rst) take1 == exp_take1)
        else report_mismatch("take1", 64'($sampled(take1)), 64'($sampled(exp_take1)));
    a_tail0: assert property (@(posedge clk) disable iff (rst) tail0 == m_tail)
        else report_mismatch("tail0", 64'($sampled(tail0)), 64'($sampled(m_tail)));
    a_tail1: assert property (@(posedge clk) disable iff (rst)
        tail1 == PTR_W'(m_tail + 1'b1))
        else report_mismatch("tail1", 64'($sampled(tail1)), 64'($sampled(m_tail + 1'b1)));
    a_head: assert property (@(posedge clk) disable iff (rst) head == m_head)
        else report_mismatch("head", 64'($sampled(head)), 64'($sampled(m_head)));
    // Payload of an invalid head entry is stale and not compared
    a_head_entry: assert property (@(posedge clk) disable iff (rst)
        head_entry.v == m_v[m_head] && (!m_v[m_head] || head_entry.instr == m_ins[m_head]))
        else report_mismatch("head_entry", 64'($sampled(head_entry)),
                             64'($sampled({m_v[m_head], m_ins[m_head]})));

    // ======================================================================
    // Stimulus helpers
    // ======================================================================

    function automatic iq_pkg::instruction_t plain_instr();
        iq_pkg::instruction_t ins;
        ins = iq_pkg::instruction_t'($urandom);
        // Keep random words off the branch opcode
        if (ins.raw.opcode == `OP_BRANCH) ins.raw.opcode = 7'h13;
        return ins;
    endfunction

    function automatic iq_pkg::instruction_t branch_instr(input logic back);
        iq_pkg::instruction_t ins;
        ins = iq_pkg::instruction_t'($urandom);
        ins.br.opcode = `OP_BRANCH;
        ins.br.disp[`INSTR_W-13] = back;
        return ins;
    endfunction

    task automatic idle(input int n);
        repeat (n) @(posedge clk);
    endtask

    task automatic put_slots(input logic v0, input iq_pkg::instruction_t i0,
                             input logic v1, input iq_pkg::instruction_t i1);
        @(posedge clk);
        fetch0.v     <= v0;
        fetch0.instr <= i0;
        fetch1.v     <= v1;
        fetch1.instr <= i1;
    endtask

    // Holds each slot until its strobe is seen, then drops its valid
    task automatic wait_taken(input int limit);
        int   n;
        logic p0;
        logic p1;
        n = 0;
        @(negedge clk);
        p0 = fetch0.v;
        p1 = fetch1.v;
        while ((p0 || p1) && n < limit) begin
            if (take0) p0 = 1'b0;
            if (take1) p1 = 1'b0;
            @(posedge clk);
            fetch0.v <= p0;
            fetch1.v <= p1;
            n++;
            @(negedge clk);
        end
        if (p0 || p1) begin
            errors++;
            $display("Timeout at %0t: fetch slots were not taken in %0d cycles", $time, limit);
        end
    endtask

    task automatic offer(input logic v0, input iq_pkg::instruction_t i0,
                         input logic v1, input iq_pkg::instruction_t i1);
        put_slots(v0, i0, v1, i1);
        wait_taken(20);
    endtask

    task automatic pulse_retire();
        @(posedge clk);
        retire <= 1'b1;
        @(posedge clk);
        retire <= 1'b0;
    endtask

    task automatic pulse_miss(input logic [PTR_W-1:0] idx);
        @(posedge clk);
        branchmiss <= 1'b1;
        miss_idx   <= idx;
        @(posedge clk);
        branchmiss <= 1'b0;
    endtask

    // Retires until the head entry reads invalid
    task automatic drain();
        int n;
        n = 0;
        @(negedge clk);
        while (head_entry.v && n < 20) begin
            pulse_retire();
            @(negedge clk);
            n++;
        end
        if (head_entry.v) begin
            errors++;
            $display("Timeout at %0t: queue did not empty after %0d retires", $time, n);
        end
    endtask

    task automatic close_test(input string name);
        test_num++;
        if (errors != errs_at_start) tests_failed++;
        $display("test %0d %s: %s", test_num, name, (errors == errs_at_start) ? "pass" : "fail");
        errs_at_start = errors;
    endtask

    // ======================================================================
    // Test sequence
    // ======================================================================

    initial begin
        logic [1:0] v;
        void'($urandom(32'h22e7));
        rst        = 1'b1;
        fetch0     = '0;
        fetch1     = '0;
        retire     = 1'b0;
        branchmiss = 1'b0;
        miss_idx   = '0;
        repeat (5) @(posedge clk);
        rst <= 1'b0;

        idle(3);
        close_test("reset state");

        offer(1'b1, plain_instr(), 1'b0, plain_instr());
        offer(1'b0, plain_instr(), 1'b1, plain_instr());
        drain();
        close_test("single slot");

        // Three pairs from tail 2 wrap the tails past entry 7
        repeat (3) offer(1'b1, plain_instr(), 1'b1, plain_instr());
        drain();
        repeat (4) begin
            v = 2'($urandom_range(3, 1));
            offer(v[0], plain_instr(), v[1], plain_instr());
        end
        drain();
        close_test("slot pairs and wrap");

        offer(1'b1, branch_instr(1'b1), 1'b1, plain_instr());
        offer(1'b1, branch_instr(1'b0), 1'b1, plain_instr());
        drain();
        close_test("branch direction");

        // Fill all eight entries, then free them one at a time
        repeat (4) offer(1'b1, plain_instr(), 1'b1, plain_instr());
        put_slots(1'b1, plain_instr(), 1'b1, plain_instr());
        fork
            wait_taken(40);
            begin
                idle(4);
                pulse_retire();
                idle(3);
                pulse_retire();
            end
        join
        drain();
        close_test("full queue");

        // Six entries, mispredict on the third, a forward branch
        repeat (3) offer(1'b1, branch_instr(1'b0), 1'b1, plain_instr());
        pulse_miss(m_tail - PTR_W'(4));
        drain();
        close_test("mispredict squash");

        $display("tests run %0d, tests failed %0d, check errors %0d",
                 test_num, tests_failed, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

//--- src/iq_macros.svh
/* Sizes of the instruction queue. The depth must stay a power of two equal to
   2**IQ_PTR_W, because the pointers wrap by plain overflow */
`ifndef IQ_MACROS_SVH
`define IQ_MACROS_SVH

// ======================================================================
// Queue geometry
// ======================================================================

// Number of entries in the queue
`define IQ_DEPTH 8

// Width of the head and tail pointers
`define IQ_PTR_W 3

// ======================================================================
// Instruction format
// ======================================================================

// Width of one instruction word
`define INSTR_W 32

// Opcode of a conditional branch, the only format that is decoded here
`define OP_BRANCH 7'h63

`endif

//--- src/iq_pkg.sv
/* Types shared by the queue blocks. Only the branch format is decoded,
   and every other opcode is carried as an opaque payload */
`include "iq_macros.svh"

package iq_pkg;

    // Raw view of a word, with the opcode in the top seven bits
    typedef struct packed {
        logic [6:0]            opcode;
        logic [`INSTR_W-8:0]   payload;
    } raw_view_t;

    // Branch view of the same word
    // The displacement is signed and its top bit gives the direction
    typedef struct packed {
        logic [6:0]            opcode;
        logic [4:0]            cond_reg;
        logic [`INSTR_W-13:0]  disp;
    } branch_view_t;

    // One instruction word seen through either view
    typedef union packed {
        raw_view_t    raw;
        branch_view_t br;
    } instruction_t;

    // A queue entry and a fetch slot have the same shape
    typedef struct packed {
        logic         v;
        instruction_t instr;
    } iq_entry_t;

    typedef struct packed {
        logic         v;
        instruction_t instr;
    } fetch_slot_t;

    // A backward branch is a branch whose displacement is negative
    function automatic logic is_back_branch(instruction_t ins);
        return (ins.raw.opcode == `OP_BRANCH) && ins.br.disp[`INSTR_W-13];
    endfunction

endpackage

//--- src/iq_stomp.sv
/* Pure combinational squash mask. The clock input serves only the check on
   miss_idx, and a mispredict at a full queue with miss_idx at tail0 stomps the rest */
`timescale 1ns/1ps
`include "iq_macros.svh"

module iq_stomp (
    input  logic                      clk,
    input  logic                      branchmiss,
    input  logic [`IQ_PTR_W-1:0]      miss_idx,
    input  logic [`IQ_PTR_W-1:0]      tail0,
    input  logic [`IQ_DEPTH-1:0]      iq_valid,
    output logic [`IQ_DEPTH-1:0]      stomp
);

    localparam int DEPTH = `IQ_DEPTH;
    localparam int PTR_W = `IQ_PTR_W;

    // ======================================================================
    // Circular range after miss_idx and before tail0
    // ======================================================================

    // Distances are taken from miss_idx, so the wrap at entry 7 falls out
    // of the pointer arithmetic without a special case
    always_comb begin
        logic [PTR_W-1:0] dist_t;
        logic [PTR_W-1:0] dist_i;
        dist_t = tail0 - miss_idx;
        stomp  = '0;
        for (int i = 0; i < DEPTH; i++) begin
            dist_i = PTR_W'(i) - miss_idx;
            // A zero distance to tail0 means the queue is full and every
            // other entry is younger than the branch
            if (branchmiss && iq_valid[i] && dist_i != '0 &&
                (dist_t == '0 || dist_i < dist_t)) begin
                stomp[i] = 1'b1;
            end
        end
    end

    // The mispredicted branch itself has to be in the queue
    a_miss_valid: assert property (@(posedge clk)
        branchmiss |-> iq_valid[miss_idx])
        else $error("branchmiss at empty entry %0d", miss_idx);

endmodule

//--- src/iq_store.sv
/* Entry storage with head retire. Writes come only from the tail block, which
   never writes during a mispredict, and retire handles one entry per pulse */
`timescale 1ns/1ps
`include "iq_macros.svh"

module iq_store (
    input  logic                      clk,
    input  logic                      rst,
    input  iq_pkg::fetch_slot_t       fetch0,
    input  iq_pkg::fetch_slot_t       fetch1,
    input  logic                      enq0,
    input  logic                      enq1,
    input  logic                      enq_sel0,
    input  logic [`IQ_PTR_W-1:0]      tail0,
    input  logic [`IQ_PTR_W-1:0]      tail1,
    input  logic [`IQ_DEPTH-1:0]      stomp,
    input  logic                      retire,
    output logic [`IQ_DEPTH-1:0]      iq_valid,
    output logic [`IQ_PTR_W-1:0]      head,
    output iq_pkg::iq_entry_t         head_entry
);

    localparam int DEPTH = `IQ_DEPTH;

    iq_pkg::iq_entry_t [DEPTH-1:0] q;
    iq_pkg::iq_entry_t             wr0;
    iq_pkg::iq_entry_t             wr1;
    logic                          do_retire;

    // ======================================================================
    // Write data
    // ======================================================================

    // Slot 1 goes to tail0 when it arrives alone
    always_comb begin
        wr0.v     = 1'b1;
        wr0.instr = enq_sel0 ? fetch1.instr : fetch0.instr;
        wr1.v     = 1'b1;
        wr1.instr = fetch1.instr;
    end

    // Retire only takes an entry that is really there
    assign do_retire = retire && q[head].v;

    // ======================================================================
    // Entry array and head pointer
    // ======================================================================

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            q    <= '0;
            head <= '0;
        end else begin
            // Squash the younger side of a mispredict
            for (int i = 0; i < DEPTH; i++) begin
                if (stomp[i]) begin
                    q[i].v <= 1'b0;
                end
            end
            if (do_retire) begin
                q[head].v <= 1'b0;
                head      <= head + 1'b1;
            end
            // New entries only land on free slots, so they never collide
            // with a squash or a retire of the same entry
            if (enq0) begin
                q[tail0] <= wr0;
            end
            if (enq1) begin
                q[tail1] <= wr1;
            end
        end
    end

    // Valid vector for the tail and stomp blocks
    always_comb begin
        for (int i = 0; i < DEPTH; i++) begin
            iq_valid[i] = q[i].v;
        end
    end

    assign head_entry = q[head];

    // The tail block must only enqueue into free entries
    a_no_overwrite: assert property (@(posedge clk) disable iff (rst)
        (enq0 |-> !iq_valid[tail0]) and (enq1 |-> !iq_valid[tail1]))
        else $error("enqueue over a valid entry at tail %0d or %0d", tail0, tail1);

endmodule

//--- src/iq_tail.sv
/* Fetch slots are levels and must be held until taken. No enqueue happens in
   a cycle with branchmiss high, and the rollback assumes one stomped run */
`timescale 1ns/1ps
`include "iq_macros.svh"

module iq_tail (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      branchmiss,
    input  iq_pkg::fetch_slot_t       fetch0,
    input  iq_pkg::fetch_slot_t       fetch1,
    input  logic [`IQ_DEPTH-1:0]      iq_valid,
    input  logic [`IQ_DEPTH-1:0]      stomp,
    output logic [`IQ_PTR_W-1:0]      tail0,
    output logic [`IQ_PTR_W-1:0]      tail1,
    output logic                      enq0,
    output logic                      enq1,
    output logic                      enq_sel0,
    output logic                      take0,
    output logic                      take1
);

    localparam int DEPTH = `IQ_DEPTH;
    localparam int PTR_W = `IQ_PTR_W;

    logic                 free0;
    logic                 free1;
    logic [1:0]           n_enq;
    logic                 roll_hit;
    logic [PTR_W-1:0]     roll_ptr;

    // ======================================================================
    // Enqueue decision
    // ======================================================================

    assign free0 = ~iq_valid[tail0];
    assign free1 = ~iq_valid[tail1];

    always_comb begin
        enq0     = 1'b0;
        enq1     = 1'b0;
        enq_sel0 = 1'b0;
        take0    = 1'b0;
        take1    = 1'b0;
        if (!branchmiss && free0) begin
            case ({fetch0.v, fetch1.v})
                2'b01: begin
                    // A lone slot 1 still lands at tail0
                    enq0     = 1'b1;
                    enq_sel0 = 1'b1;
                    take1    = 1'b1;
                end
                2'b10: begin
                    enq0  = 1'b1;
                    take0 = 1'b1;
                end
                2'b11: begin
                    enq0  = 1'b1;
                    take0 = 1'b1;
                    // A backward branch ends the fetch group, so slot 1 waits
                    if (!iq_pkg::is_back_branch(fetch0.instr) && free1) begin
                        enq1  = 1'b1;
                        take1 = 1'b1;
                    end
                end
                default: ;
            endcase
        end
    end

    assign n_enq = {1'b0, enq0} + {1'b0, enq1};

    // ======================================================================
    // Rollback point on a mispredict
    // ======================================================================

    // The new tail is the first stomped entry, found where the circular mask rises
    // Scanning downward lets the lowest index win if there is more than one edge
    always_comb begin
        roll_hit = 1'b0;
        roll_ptr = '0;
        for (int i = DEPTH - 1; i >= 0; i--) begin
            if (stomp[i] && !stomp[PTR_W'(i - 1)]) begin
                roll_hit = 1'b1;
                roll_ptr = PTR_W'(i);
            end
        end
    end

    // Tail pair update
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            tail0 <= '0;
            tail1 <= PTR_W'(1);
        end else if (branchmiss) begin
            // With nothing stomped the tails hold
            if (roll_hit) begin
                tail0 <= roll_ptr;
                tail1 <= roll_ptr + 1'b1;
            end
        end else begin
            tail0 <= tail0 + PTR_W'(n_enq);
            tail1 <= tail1 + PTR_W'(n_enq);
        end
    end

    // The pair moves together through enqueue and rollback alike
    a_tail_pair: assert property (@(posedge clk) disable iff (rst)
        tail1 == PTR_W'(tail0 + 1'b1))
        else $error("tail1 %0d is not tail0 %0d plus one", tail1, tail0);

endmodule

//--- src/iq_top.sv
/* Enqueue side of the instruction queue. Fetch slots are held levels and
   branchmiss and retire are single-cycle pulses */
`timescale 1ns/1ps
`include "iq_macros.svh"

module iq_top (
    input  logic                      clk,
    input  logic                      rst,
    input  iq_pkg::fetch_slot_t       fetch0,
    input  iq_pkg::fetch_slot_t       fetch1,
    input  logic                      retire,
    input  logic                      branchmiss,
    input  logic [`IQ_PTR_W-1:0]      miss_idx,
    output logic                      take0,
    output logic                      take1,
    output logic [`IQ_PTR_W-1:0]      tail0,
    output logic [`IQ_PTR_W-1:0]      tail1,
    output logic [`IQ_PTR_W-1:0]      head,
    output iq_pkg::iq_entry_t         head_entry
);

    // ======================================================================
    // Internal connections
    // ======================================================================

    logic [`IQ_DEPTH-1:0] iq_valid;
    logic [`IQ_DEPTH-1:0] stomp;
    logic                 enq0;
    logic                 enq1;
    logic                 enq_sel0;

    // Tail pair and enqueue strobes
    iq_tail tail_i (
        .clk, .rst, .branchmiss, .fetch0, .fetch1, .iq_valid, .stomp,
        .tail0, .tail1, .enq0, .enq1, .enq_sel0, .take0, .take1
    );

    // Squash mask for a mispredict
    iq_stomp stomp_i (
        .clk, .branchmiss, .miss_idx, .tail0, .iq_valid, .stomp
    );

    // Entries, head pointer and retire
    iq_store store_i (
        .clk, .rst, .fetch0, .fetch1, .enq0, .enq1, .enq_sel0,
        .tail0, .tail1, .stomp, .retire,
        .iq_valid, .head, .head_entry
    );

endmodule
